/* design/mlkem_masked_pkg.sv */
package mlkem_masked_pkg;

    // ML-KEM modulus and coefficient width
    localparam int unsigned MLKEM_Q = 3329;
    localparam int unsigned COEFF_WIDTH = 12;

    // Input sampled to valid_o
    localparam int unsigned PIPE_LATENCY = 5;

    // Fresh words consumed per beat
    localparam int unsigned BF_RND_WORDS = 2;
    localparam int unsigned SPLIT_RND_WORDS = 6;
    localparam int unsigned RND_WORDS = SPLIT_RND_WORDS + 2 * BF_RND_WORDS;

    // Right-shifting Galois taps for x^16 + x^14 + x^13 + x^11 + 1
    localparam int unsigned LFSR_WIDTH = 16;
    localparam logic [LFSR_WIDTH-1:0] LFSR_TAPS = 16'hB400;

    // One non-zero start value per lane, lane 0 rightmost
    localparam logic [RND_WORDS-1:0][LFSR_WIDTH-1:0] RNG_SEEDS = {
        16'hB04D, 16'h26F8, 16'h9C13, 16'hE4A5, 16'h3B96,
        16'h7F21, 16'hC0DE, 16'h5A3C, 16'h1D87, 16'hACE1
    };

    typedef logic [COEFF_WIDTH-1:0] coeff_t;

    // Value is (share0 + share1) mod q
    typedef struct packed {
        coeff_t share1;
        coeff_t share0;
    } masked_coeff_t;

    typedef struct packed {
        coeff_t u00;
        coeff_t v00;
        coeff_t w00;
        coeff_t u01;
        coeff_t v01;
        coeff_t w01;
    } bf_plain_in_t;

    typedef struct packed {
        masked_coeff_t u00;
        masked_coeff_t v00;
        masked_coeff_t w00;
        masked_coeff_t u01;
        masked_coeff_t v01;
        masked_coeff_t w01;
    } bf_masked_in_t;

    typedef struct packed {
        coeff_t u20;
        coeff_t u21;
        coeff_t v20;
        coeff_t v21;
    } bf_uv_out_t;

    typedef coeff_t [RND_WORDS-1:0] rnd_bus_t;

    // Both operands must already be below q
    function automatic coeff_t add_mod(input coeff_t a, input coeff_t b);
        logic [COEFF_WIDTH:0] sum;
        sum = a + b;
        if (sum >= MLKEM_Q) begin
            sum = sum - (COEFF_WIDTH + 1)'(MLKEM_Q);
        end
        return sum[COEFF_WIDTH-1:0];
    endfunction

    function automatic coeff_t sub_mod(input coeff_t a, input coeff_t b);
        if (a >= b) begin
            return a - b;
        end
        return coeff_t'(a + MLKEM_Q - b);
    endfunction

endpackage

/* design/mask_rng.sv */
`timescale 1ns/1ps

module mask_rng (
    input  logic                        clk,
    input  logic                        reset_n,
    output mlkem_masked_pkg::rnd_bus_t  rnd_o
);
    import mlkem_masked_pkg::*;

    logic [RND_WORDS-1:0][LFSR_WIDTH-1:0] lane_q;
    logic [RND_WORDS-1:0][LFSR_WIDTH-1:0] lane_d;

    for (genvar i = 0; i < RND_WORDS; i++) begin : g_lane
        coeff_t low;

        // One Galois step per cycle
        assign lane_d[i] = {1'b0, lane_q[i][LFSR_WIDTH-1:1]}
                         ^ (lane_q[i][0] ? LFSR_TAPS : '0);

        // Low bits folded once so the word stays below q
        assign low = lane_q[i][COEFF_WIDTH-1:0];
        assign rnd_o[i] = (low >= MLKEM_Q) ? coeff_t'(low - MLKEM_Q) : low;
    end

    // Lanes keep running through zeroize
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            lane_q <= RNG_SEEDS;
        end
        else begin
            lane_q <= lane_d;
        end
    end

endmodule

/* design/mask_share_split.sv */
`timescale 1ns/1ps

module mask_share_split (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  logic                                   zeroize_i,
    input  mlkem_masked_pkg::bf_plain_in_t         plain_i,
    input  mlkem_masked_pkg::coeff_t [mlkem_masked_pkg::SPLIT_RND_WORDS-1:0] rnd_i,
    output mlkem_masked_pkg::bf_masked_in_t        masked_o
);
    import mlkem_masked_pkg::*;

    bf_masked_in_t masked_d;

    // Mask word becomes share0 and the remainder share1
    function automatic masked_coeff_t split_coeff(input coeff_t x, input coeff_t r);
        masked_coeff_t res;
        res.share0 = r;
        res.share1 = sub_mod(x, r);
        return res;
    endfunction

    always_comb begin
        masked_d.u00 = split_coeff(plain_i.u00, rnd_i[0]);
        masked_d.v00 = split_coeff(plain_i.v00, rnd_i[1]);
        masked_d.w00 = split_coeff(plain_i.w00, rnd_i[2]);
        masked_d.u01 = split_coeff(plain_i.u01, rnd_i[3]);
        masked_d.v01 = split_coeff(plain_i.v01, rnd_i[4]);
        masked_d.w01 = split_coeff(plain_i.w01, rnd_i[5]);
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            masked_o <= '0;
        end
        else if (zeroize_i) begin
            masked_o <= '0;
        end
        else begin
            masked_o <= masked_d;
        end
    end

endmodule

/* design/masked_gs_butterfly.sv */
`timescale 1ns/1ps

module masked_gs_butterfly (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            zeroize_i,
    input  mlkem_masked_pkg::masked_coeff_t opu_i,
    input  mlkem_masked_pkg::masked_coeff_t opv_i,
    input  mlkem_masked_pkg::masked_coeff_t opw_i,
    input  mlkem_masked_pkg::coeff_t [mlkem_masked_pkg::BF_RND_WORDS-1:0] rnd_i,
    output mlkem_masked_pkg::masked_coeff_t u_o,
    output mlkem_masked_pkg::masked_coeff_t v_o
);
    import mlkem_masked_pkg::*;

    masked_coeff_t sum_s1;
    masked_coeff_t diff_s1;
    masked_coeff_t w_s1;
    masked_coeff_t sum_s2;
    coeff_t        p00_s2;
    coeff_t        p01_s2;
    coeff_t        p10_s2;
    coeff_t        p11_s2;
    coeff_t        p00;
    coeff_t        p01;
    coeff_t        p10;
    coeff_t        p11;

    function automatic coeff_t mul_mod(input coeff_t a, input coeff_t b);
        logic [2*COEFF_WIDTH-1:0] prod;
        prod = a * b;
        return coeff_t'(prod % MLKEM_Q);
    endfunction

    // Stage 1 share-wise sum and difference
    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            sum_s1  <= '0;
            diff_s1 <= '0;
            w_s1    <= '0;
        end
        else begin
            sum_s1.share0  <= add_mod(opu_i.share0, opv_i.share0);
            sum_s1.share1  <= add_mod(opu_i.share1, opv_i.share1);
            diff_s1.share0 <= sub_mod(opu_i.share0, opv_i.share0);
            diff_s1.share1 <= sub_mod(opu_i.share1, opv_i.share1);
            w_s1           <= opw_i;
        end
    end

    // Cross terms carry r0 in opposite signs so the pair cancels
    always_comb begin
        p00 = mul_mod(diff_s1.share0, w_s1.share0);
        p01 = add_mod(mul_mod(diff_s1.share0, w_s1.share1), rnd_i[0]);
        p10 = sub_mod(mul_mod(diff_s1.share1, w_s1.share0), rnd_i[0]);
        p11 = mul_mod(diff_s1.share1, w_s1.share1);
    end

    // Stage 2 partial products and sum refresh with r1
    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            sum_s2 <= '0;
            p00_s2 <= '0;
            p01_s2 <= '0;
            p10_s2 <= '0;
            p11_s2 <= '0;
        end
        else begin
            sum_s2.share0 <= add_mod(sum_s1.share0, rnd_i[1]);
            sum_s2.share1 <= sub_mod(sum_s1.share1, rnd_i[1]);
            p00_s2        <= p00;
            p01_s2        <= p01;
            p10_s2        <= p10;
            p11_s2        <= p11;
        end
    end

    // Stage 3 gathers two partial products per output share
    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            u_o <= '0;
            v_o <= '0;
        end
        else begin
            u_o       <= sum_s2;
            v_o.share0 <= add_mod(p00_s2, p01_s2);
            v_o.share1 <= add_mod(p10_s2, p11_s2);
        end
    end

endmodule

/* design/masked_butterfly1x2.sv */
`timescale 1ns/1ps

module masked_butterfly1x2 (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            zeroize_i,
    input  mlkem_masked_pkg::bf_masked_in_t uvw_i,
    input  mlkem_masked_pkg::coeff_t [2*mlkem_masked_pkg::BF_RND_WORDS-1:0] rnd_i,
    output mlkem_masked_pkg::bf_uv_out_t    uv_o
);
    import mlkem_masked_pkg::*;

    masked_coeff_t u10;
    masked_coeff_t v10;
    masked_coeff_t u11;
    masked_coeff_t v11;
    bf_uv_out_t    uv_d;

    // Odd values take the q offset first so the shift stays exact
    function automatic coeff_t half_mod(input coeff_t x);
        logic [COEFF_WIDTH:0] t;
        t = {1'b0, x} + (x[0] ? (COEFF_WIDTH + 1)'(MLKEM_Q) : '0);
        return t[COEFF_WIDTH:1];
    endfunction

    function automatic coeff_t unmask_half(input masked_coeff_t m);
        return half_mod(add_mod(m.share0, m.share1));
    endfunction

    masked_gs_butterfly i_bf00 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .opu_i     (uvw_i.u00),
        .opv_i     (uvw_i.v00),
        .opw_i     (uvw_i.w00),
        .rnd_i     (rnd_i[BF_RND_WORDS-1:0]),
        .u_o       (u10),
        .v_o       (v10)
    );

    masked_gs_butterfly i_bf01 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .opu_i     (uvw_i.u01),
        .opv_i     (uvw_i.v01),
        .opw_i     (uvw_i.w01),
        .rnd_i     (rnd_i[2*BF_RND_WORDS-1:BF_RND_WORDS]),
        .u_o       (u11),
        .v_o       (v11)
    );

    always_comb begin
        uv_d.u20 = unmask_half(u10);
        uv_d.u21 = unmask_half(v10);
        uv_d.v20 = unmask_half(u11);
        uv_d.v21 = unmask_half(v11);
    end

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            uv_o <= '0;
        end
        else begin
            uv_o <= uv_d;
        end
    end

endmodule

/* design/masked_intt_stage1.sv */
`timescale 1ns/1ps

module masked_intt_stage1 (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           zeroize_i,
    input  logic                           valid_i,
    input  mlkem_masked_pkg::bf_plain_in_t coeff_i,
    output logic                           valid_o,
    output mlkem_masked_pkg::bf_uv_out_t   uv_o
);
    import mlkem_masked_pkg::*;

    rnd_bus_t                rnd;
    bf_masked_in_t           masked_uvw;
    logic [PIPE_LATENCY-1:0] valid_sr;

    mask_rng i_mask_rng (
        .clk     (clk),
        .reset_n (reset_n),
        .rnd_o   (rnd)
    );

    // Words 0 to 5 mask the six input coefficients
    mask_share_split i_mask_share_split (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .plain_i   (coeff_i),
        .rnd_i     (rnd[SPLIT_RND_WORDS-1:0]),
        .masked_o  (masked_uvw)
    );

    // Remaining words refresh the two butterflies
    masked_butterfly1x2 i_masked_butterfly1x2 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .uvw_i     (masked_uvw),
        .rnd_i     (rnd[RND_WORDS-1:SPLIT_RND_WORDS]),
        .uv_o      (uv_o)
    );

    // Valid travels beside the data, one flop per pipeline register
    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            valid_sr <= '0;
        end
        else begin
            valid_sr <= {valid_sr[PIPE_LATENCY-2:0], valid_i};
        end
    end

    assign valid_o = valid_sr[PIPE_LATENCY-1];

endmodule

/* test/masked_intt_stage1_checker.sv */
`timescale 1ns/1ps

module masked_intt_stage1_checker (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           zeroize_i,
    input  logic                           valid_i,
    input  mlkem_masked_pkg::bf_plain_in_t coeff_i,
    input  logic                           dut_valid_i,
    input  mlkem_masked_pkg::bf_uv_out_t   dut_uv_i,
    output int unsigned                    value_errors_o,
    output int unsigned                    pulse_errors_o,
    output int unsigned                    pending_o
);
    import mlkem_masked_pkg::*;

    typedef struct packed {
        int unsigned tag;
        bf_uv_out_t  uv;
    } expect_t;

    expect_t exp_q[$];

    // Odd values borrow one q before halving
    function automatic int unsigned half_q(input int unsigned x);
        if (x % 2 == 0) begin
            return x / 2;
        end
        return (x + MLKEM_Q) / 2;
    endfunction

    // Reference butterfly pair on the plain coefficients
    function automatic bf_uv_out_t model_beat(input bf_plain_in_t c);
        bf_uv_out_t  r;
        int unsigned d0;
        int unsigned d1;
        d0 = (32'(c.u00) + MLKEM_Q - 32'(c.v00)) % MLKEM_Q;
        d1 = (32'(c.u01) + MLKEM_Q - 32'(c.v01)) % MLKEM_Q;
        r.u20 = coeff_t'(half_q((32'(c.u00) + 32'(c.v00)) % MLKEM_Q));
        r.u21 = coeff_t'(half_q((d0 * 32'(c.w00)) % MLKEM_Q));
        r.v20 = coeff_t'(half_q((32'(c.u01) + 32'(c.v01)) % MLKEM_Q));
        r.v21 = coeff_t'(half_q((d1 * 32'(c.w01)) % MLKEM_Q));
        return r;
    endfunction

    // Inputs are taken at the rising edge and outputs judged at the falling edge
    initial begin
        int unsigned             edge_cnt;
        logic [PIPE_LATENCY-1:0] zero_sr;
        expect_t                 entry;
        coeff_t [3:0]            got;
        coeff_t [3:0]            want;
        string                   names [4];
        value_errors_o = 0;
        pulse_errors_o = 0;
        pending_o      = 0;
        edge_cnt       = 0;
        zero_sr        = '1;
        names          = '{"v21", "v20", "u21", "u20"};
        forever begin
            @(posedge clk);
            edge_cnt++;
            // Beats in flight are dropped together with the data
            if (!reset_n || zeroize_i) begin
                exp_q.delete();
                zero_sr = '1;
            end
            else begin
                // An all-zero input leaves as zero whatever the masks were
                zero_sr = {zero_sr[PIPE_LATENCY-2:0], coeff_i == '0};
                if (valid_i) begin
                    entry.tag = edge_cnt;
                    entry.uv  = model_beat(coeff_i);
                    exp_q.push_back(entry);
                end
            end

            @(negedge clk);
            if (zero_sr[PIPE_LATENCY-1] && dut_uv_i !== '0) begin
                $display("error at time %0t: uv_o is %h but only zeros are in the pipeline",
                         $time, dut_uv_i);
                value_errors_o++;
            end
            if (dut_valid_i === 1'b1 && exp_q.size() == 0) begin
                $display("valid_o went high at time %0t with no beat in flight", $time);
                pulse_errors_o++;
            end
            else if (dut_valid_i === 1'b1) begin
                entry = exp_q.pop_front();
                if (entry.tag + PIPE_LATENCY - 1 != edge_cnt) begin
                    $display("valid_o at time %0t came at edge %0d instead of edge %0d",
                             $time, edge_cnt, entry.tag + PIPE_LATENCY - 1);
                    pulse_errors_o++;
                end
                got  = dut_uv_i;
                want = entry.uv;
                for (int k = 3; k >= 0; k--) begin
                    if (got[k] !== want[k]) begin
                        $display("error at time %0t: %s got %0d expected %0d",
                                 $time, names[k], got[k], want[k]);
                        value_errors_o++;
                    end
                end
            end
            else if (dut_valid_i !== 1'b0) begin
                $display("valid_o is unknown at time %0t", $time);
                pulse_errors_o++;
            end
            else if (exp_q.size() != 0 && exp_q[0].tag + PIPE_LATENCY - 1 <= edge_cnt) begin
                $display("valid_o stayed low at time %0t although a beat was due", $time);
                pulse_errors_o++;
                entry = exp_q.pop_front();
            end
            pending_o = exp_q.size();
        end
    end

endmodule

/* test/masked_intt_stage1_tb.sv */
`timescale 1ns/1ps

module masked_intt_stage1_tb;
    import mlkem_masked_pkg::*;

    localparam int unsigned NUM_BEATS     = 400;
    localparam int unsigned STIM_TIMEOUT  = 4000;
    localparam int unsigned DRAIN_TIMEOUT = 40;

    logic         clk;
    logic         reset_n;
    logic         zeroize;
    logic         valid_in;
    bf_plain_in_t coeff;
    logic         valid_out;
    bf_uv_out_t   uv;
    int unsigned  value_errors;
    int unsigned  pulse_errors;
    int unsigned  pending;
    int           seed;
    int unsigned  beats_sent;
    int unsigned  cycles;
    int unsigned  zeroize_left;

    masked_intt_stage1 i_masked_intt_stage1 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize),
        .valid_i   (valid_in),
        .coeff_i   (coeff),
        .valid_o   (valid_out),
        .uv_o      (uv)
    );

    masked_intt_stage1_checker i_checker (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize_i      (zeroize),
        .valid_i        (valid_in),
        .coeff_i        (coeff),
        .dut_valid_i    (valid_out),
        .dut_uv_i       (uv),
        .value_errors_o (value_errors),
        .pulse_errors_o (pulse_errors),
        .pending_o      (pending)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Mostly uniform below q with both end values forced now and then
    function automatic coeff_t draw_coeff();
        int unsigned pick;
        pick = $unsigned($random(seed)) % 16;
        if (pick == 0) begin
            return '0;
        end
        if (pick == 1) begin
            return coeff_t'(MLKEM_Q - 1);
        end
        return coeff_t'($unsigned($random(seed)) % MLKEM_Q);
    endfunction

    task automatic drive_beat(input logic force_valid);
        coeff.u00 = draw_coeff();
        coeff.v00 = draw_coeff();
        coeff.w00 = draw_coeff();
        coeff.u01 = draw_coeff();
        coeff.v01 = draw_coeff();
        coeff.w01 = draw_coeff();
        valid_in  = force_valid || (($unsigned($random(seed)) % 10) < 7);
        // Zeroize pulses last one to three cycles
        if (zeroize_left != 0) begin
            zeroize_left--;
            zeroize = 1'b1;
        end
        else if (!force_valid && ($unsigned($random(seed)) % 64) == 0) begin
            zeroize_left = $unsigned($random(seed)) % 3;
            zeroize      = 1'b1;
        end
        else begin
            zeroize = 1'b0;
        end
    endtask

    initial begin
        seed         = 32'h6e20_ee11;
        reset_n      = 1'b0;
        zeroize      = 1'b0;
        valid_in     = 1'b0;
        coeff        = '0;
        beats_sent   = 0;
        zeroize_left = 0;
        repeat (5) @(negedge clk);
        reset_n = 1'b1;
        // Idle zero inputs keep uv_o at zero for a while after reset
        repeat (8) @(negedge clk);
        cycles = 0;
        // The first beats go back to back
        while (beats_sent < NUM_BEATS && cycles < STIM_TIMEOUT) begin
            drive_beat(cycles < 8);
            if (valid_in && !zeroize) begin
                beats_sent++;
            end
            cycles++;
            @(negedge clk);
        end
        valid_in = 1'b0;
        zeroize  = 1'b0;
        coeff    = '0;
        if (beats_sent < NUM_BEATS) begin
            $display("timeout: only %0d of %0d beats were sent", beats_sent, NUM_BEATS);
            $display("TEST FAILED");
            $finish;
        end
        else begin
            cycles = 0;
            // Queue depth and error counts settle at the falling edge
            @(posedge clk);
            while (pending != 0 && cycles < DRAIN_TIMEOUT) begin
                @(posedge clk);
                cycles++;
            end
            if (pending != 0) begin
                $display("timeout: %0d beats never came out of the pipeline", pending);
                $display("TEST FAILED");
                $finish;
            end
            else begin
                // A quiet tail catches stray valid_o pulses
                repeat (2 * PIPE_LATENCY) @(posedge clk);
                $display("%0d beats sent, %0d value errors, %0d pulse errors",
                         beats_sent, value_errors, pulse_errors);
                if (value_errors == 0 && pulse_errors == 0) begin
                    $display("TEST PASSED");
                end
                else begin
                    $display("TEST FAILED");
                end
                $finish;
            end
        end
    end

endmodule

/* masked_intt_stage1.f */
design/mlkem_masked_pkg.sv
design/mask_rng.sv
design/mask_share_split.sv
design/masked_gs_butterfly.sv
design/masked_butterfly1x2.sv
design/masked_intt_stage1.sv
test/masked_intt_stage1_checker.sv
test/masked_intt_stage1_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the stage-1 testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --top-module masked_intt_stage1_tb \
    -f masked_intt_stage1.f -o masked_intt_stage1_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/masked_intt_stage1_sim > sim.log 2>&1
cat sim.log
grep -qx "TEST PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
